/* rtl/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

  localparam int xlen       = 32;   // Data and address width
  localparam int reg_addr_w = 5;
  localparam int pc_step    = 4;    // Bytes per instruction

  typedef logic [xlen-1:0]       word_t;
  typedef logic [reg_addr_w-1:0] reg_addr_t;

  typedef enum logic [5:0] {
    op_rtype = 6'h00,               // Operation chosen by funct
    op_beq   = 6'h04,
    op_bne   = 6'h05,
    op_addi  = 6'h08,
    op_slti  = 6'h0A,
    op_lw    = 6'h23,
    op_sw    = 6'h2B                // Stores register rd
  } opcode_e;

  typedef enum logic [6:0] {
    fn_add = 7'h20,
    fn_sub = 7'h22,
    fn_slt = 7'h2A                  // Signed compare
  } funct_e;

  // Operand source once the instruction reaches execute
  typedef enum logic [1:0] {
    fwd_none,                       // Value read in decode
    fwd_mem,
    fwd_wb,
    fwd_retire
  } fwd_sel_e;

endpackage

`default_nettype wire

/* rtl/reg_file.sv */
`default_nettype none

module reg_file (
  input  logic               clk,
  input  logic               nrst,
  input  cpu_pkg::reg_addr_t rd_addr_a,
  input  cpu_pkg::reg_addr_t rd_addr_b,
  input  logic               wr_en,
  input  cpu_pkg::reg_addr_t wr_addr,
  input  cpu_pkg::word_t     wr_data,
  output cpu_pkg::word_t     rd_data_a,
  output cpu_pkg::word_t     rd_data_b
);

  cpu_pkg::word_t regs [2**cpu_pkg::reg_addr_w];

  assign rd_data_a = regs[rd_addr_a];
  assign rd_data_b = regs[rd_addr_b];

  always_ff @(posedge clk) begin
    if (!nrst) begin
      for (int i = 0; i < 2**cpu_pkg::reg_addr_w; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && wr_addr != '0) begin   // r0 stays zero
      regs[wr_addr] <= wr_data;
    end
  end

endmodule

`default_nettype wire

/* rtl/hazard_unit.sv */
`default_nettype none

module hazard_unit (
  input  cpu_pkg::reg_addr_t src_a,
  input  cpu_pkg::reg_addr_t src_b,
  input  logic               use_a,
  input  logic               use_b,
  input  logic               ex_reg_write,
  input  logic               ex_load,
  input  cpu_pkg::reg_addr_t ex_dest,
  input  logic               mem_reg_write,
  input  cpu_pkg::reg_addr_t mem_dest,
  input  logic               wb_reg_write,
  input  cpu_pkg::reg_addr_t wb_dest,
  output logic               stall,
  output cpu_pkg::fwd_sel_e  fwd_a,
  output cpu_pkg::fwd_sel_e  fwd_b
);

  logic live_a;
  logic live_b;
  logic ex_hit_a;
  logic ex_hit_b;

  assign live_a = use_a && (src_a != '0);
  assign live_b = use_b && (src_b != '0);

  assign ex_hit_a = live_a && ex_reg_write && (src_a == ex_dest);
  assign ex_hit_b = live_b && ex_reg_write && (src_b == ex_dest);

  // A load result is not ready until memory so decode holds once
  assign stall = ex_load && (ex_hit_a || ex_hit_b);

  // Selects name the producer position one cycle from now
  function automatic cpu_pkg::fwd_sel_e pick(input logic live, input cpu_pkg::reg_addr_t src);
    cpu_pkg::fwd_sel_e sel;
    sel = cpu_pkg::fwd_none;
    if (live) begin
      if (ex_reg_write && src == ex_dest) begin
        sel = cpu_pkg::fwd_mem;         // Youngest producer first
      end else if (mem_reg_write && src == mem_dest) begin
        sel = cpu_pkg::fwd_wb;
      end else if (wb_reg_write && src == wb_dest) begin
        sel = cpu_pkg::fwd_retire;      // Register file write lands too late
      end
    end
    return sel;
  endfunction

  always_comb begin
    fwd_a = pick(live_a, src_a);
    fwd_b = pick(live_b, src_b);
  end

endmodule

`default_nettype wire

/* rtl/fetch_stage.sv */
`default_nettype none

module fetch_stage (
  input  logic           clk,
  input  logic           nrst,
  input  cpu_pkg::word_t inst,
  input  logic           stall,
  input  logic           branch_taken,
  input  cpu_pkg::word_t branch_target,
  output cpu_pkg::word_t inst_addr,
  output cpu_pkg::word_t if_inst,
  output cpu_pkg::word_t if_pc_next
);

  cpu_pkg::word_t pc;
  cpu_pkg::word_t pc_plus;

  assign pc_plus   = pc + cpu_pkg::word_t'(cpu_pkg::pc_step);
  assign inst_addr = pc;

  // Taken branch wins over a load-use hold
  always_ff @(posedge clk) begin
    if (!nrst) begin
      pc      <= '0;
      if_inst <= '0;                    // Zero word is add to r0
    end else if (branch_taken) begin
      pc      <= branch_target;
      if_inst <= '0;                    // Drop wrong-path fetch
    end else if (!stall) begin
      pc      <= pc_plus;
      if_inst <= inst;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      if_pc_next <= pc_plus;
    end
  end

endmodule

`default_nettype wire

/* rtl/decode_stage.sv */
`default_nettype none

module decode_stage (
  input  logic               clk,
  input  logic               nrst,
  input  cpu_pkg::word_t     if_inst,
  input  cpu_pkg::word_t     if_pc_next,
  input  logic               branch_taken,
  input  logic               ex_reg_write,
  input  logic               ex_load,
  input  cpu_pkg::reg_addr_t ex_dest,
  input  cpu_pkg::reg_addr_t mem_dest,
  input  logic               mem_reg_write,
  input  logic               wb_reg_write,
  input  cpu_pkg::reg_addr_t wb_dest,
  input  cpu_pkg::word_t     wb_result,
  output logic               stall,
  output cpu_pkg::opcode_e   id_op,
  output cpu_pkg::funct_e    id_funct,
  output cpu_pkg::word_t     id_a,
  output cpu_pkg::word_t     id_b,
  output cpu_pkg::word_t     id_imm,
  output cpu_pkg::word_t     id_pc_next,
  output cpu_pkg::reg_addr_t id_dest,
  output cpu_pkg::fwd_sel_e  id_fwd_a,
  output cpu_pkg::fwd_sel_e  id_fwd_b
);

  cpu_pkg::opcode_e   op;
  cpu_pkg::reg_addr_t rd;
  cpu_pkg::reg_addr_t rs1;
  cpu_pkg::reg_addr_t src_b;
  cpu_pkg::word_t     imm_alu;
  cpu_pkg::word_t     imm_bra;
  cpu_pkg::word_t     rf_a;
  cpu_pkg::word_t     rf_b;
  cpu_pkg::fwd_sel_e  fwd_a;
  cpu_pkg::fwd_sel_e  fwd_b;
  logic               is_branch;
  logic               use_a;
  logic               use_b;

  assign op      = cpu_pkg::opcode_e'(if_inst[5:0]);
  assign rd      = if_inst[10:6];
  assign rs1     = if_inst[19:15];
  assign src_b   = (op == cpu_pkg::op_sw) ? rd : if_inst[24:20];   // sw reads rd
  assign imm_alu = {{16{if_inst[31]}}, if_inst[31:20], if_inst[14:11]};
  assign imm_bra = {{16{if_inst[31]}}, if_inst[31:25], if_inst[14:6]};

  assign is_branch = (op == cpu_pkg::op_beq) || (op == cpu_pkg::op_bne);

  always_comb begin
    case (op)
      cpu_pkg::op_rtype, cpu_pkg::op_beq, cpu_pkg::op_bne, cpu_pkg::op_sw: begin
        use_a = 1'b1;
        use_b = 1'b1;
      end
      cpu_pkg::op_addi, cpu_pkg::op_slti, cpu_pkg::op_lw: begin
        use_a = 1'b1;
        use_b = 1'b0;
      end
      default: begin                    // Unknown opcode reads nothing
        use_a = 1'b0;
        use_b = 1'b0;
      end
    endcase
  end

  reg_file u_rf (
    .clk       (clk),
    .nrst      (nrst),
    .rd_addr_a (rs1),
    .rd_addr_b (src_b),
    .wr_en     (wb_reg_write),
    .wr_addr   (wb_dest),
    .wr_data   (wb_result),
    .rd_data_a (rf_a),
    .rd_data_b (rf_b)
  );

  hazard_unit u_hazard (
    .src_a         (rs1),
    .src_b         (src_b),
    .use_a         (use_a),
    .use_b         (use_b),
    .ex_reg_write  (ex_reg_write),
    .ex_load       (ex_load),
    .ex_dest       (ex_dest),
    .mem_reg_write (mem_reg_write),
    .mem_dest      (mem_dest),
    .wb_reg_write  (wb_reg_write),
    .wb_dest       (wb_dest),
    .stall         (stall),
    .fwd_a         (fwd_a),
    .fwd_b         (fwd_b)
  );

  // Bubble is add to r0 with no forwarding
  always_ff @(posedge clk) begin
    if (!nrst || stall || branch_taken) begin
      id_op    <= cpu_pkg::op_rtype;
      id_dest  <= '0;
      id_fwd_a <= cpu_pkg::fwd_none;
      id_fwd_b <= cpu_pkg::fwd_none;
    end else begin
      id_op    <= op;
      id_dest  <= rd;
      id_fwd_a <= fwd_a;
      id_fwd_b <= fwd_b;
    end
  end

  always_ff @(posedge clk) begin
    id_funct   <= cpu_pkg::funct_e'(if_inst[31:25]);
    id_a       <= rf_a;
    id_b       <= rf_b;
    id_imm     <= is_branch ? imm_bra : imm_alu;
    id_pc_next <= if_pc_next;
  end

endmodule

`default_nettype wire

/* rtl/execute_stage.sv */
`default_nettype none

module execute_stage (
  input  logic               clk,
  input  logic               nrst,
  input  cpu_pkg::opcode_e   id_op,
  input  cpu_pkg::funct_e    id_funct,
  input  cpu_pkg::word_t     id_a,
  input  cpu_pkg::word_t     id_b,
  input  cpu_pkg::word_t     id_imm,
  input  cpu_pkg::word_t     id_pc_next,
  input  cpu_pkg::reg_addr_t id_dest,
  input  cpu_pkg::fwd_sel_e  id_fwd_a,
  input  cpu_pkg::fwd_sel_e  id_fwd_b,
  input  cpu_pkg::word_t     mem_result,
  input  cpu_pkg::word_t     wb_result,
  input  cpu_pkg::word_t     retire_result,
  output logic               branch_taken,
  output cpu_pkg::word_t     branch_target,
  output logic               ex_reg_write,    // Decoded from the instruction in execute
  output logic               ex_load,
  output cpu_pkg::reg_addr_t ex_dest,
  output cpu_pkg::word_t     ex_alu,
  output cpu_pkg::word_t     ex_store_data,
  output logic               ex_store         // Registered for one memory cycle
);

  cpu_pkg::word_t opnd_a;
  cpu_pkg::word_t opnd_b;
  cpu_pkg::word_t alu_b;
  cpu_pkg::word_t diff;
  cpu_pkg::word_t alu_y;
  logic           use_imm;
  logic           less;

  function automatic cpu_pkg::word_t resolve(input cpu_pkg::fwd_sel_e sel,
                                             input cpu_pkg::word_t rf_val);
    case (sel)
      cpu_pkg::fwd_mem:    return mem_result;
      cpu_pkg::fwd_wb:     return wb_result;
      cpu_pkg::fwd_retire: return retire_result;
      default:             return rf_val;
    endcase
  endfunction

  always_comb begin
    opnd_a = resolve(id_fwd_a, id_a);
    opnd_b = resolve(id_fwd_b, id_b);
  end

  assign use_imm = (id_op == cpu_pkg::op_addi) || (id_op == cpu_pkg::op_slti) ||
                   (id_op == cpu_pkg::op_lw)   || (id_op == cpu_pkg::op_sw);
  assign alu_b   = use_imm ? id_imm : opnd_b;
  assign diff    = opnd_a - alu_b;
  assign less    = $signed(opnd_a) < $signed(alu_b);

  always_comb begin
    case (id_op)
      cpu_pkg::op_rtype: begin
        case (id_funct)
          cpu_pkg::fn_add: alu_y = opnd_a + alu_b;
          cpu_pkg::fn_sub: alu_y = diff;
          cpu_pkg::fn_slt: alu_y = cpu_pkg::word_t'(less);
          default:         alu_y = '0;      // Unsupported funct gives zero
        endcase
      end
      cpu_pkg::op_addi, cpu_pkg::op_lw, cpu_pkg::op_sw: alu_y = opnd_a + alu_b;
      cpu_pkg::op_slti:                                 alu_y = cpu_pkg::word_t'(less);
      cpu_pkg::op_beq, cpu_pkg::op_bne:                 alu_y = diff;
      default:                                          alu_y = '0;
    endcase
  end

  assign branch_taken  = ((id_op == cpu_pkg::op_beq) && (diff == '0)) ||
                         ((id_op == cpu_pkg::op_bne) && (diff != '0));
  assign branch_target = id_pc_next + id_imm;   // Offset relative to PC plus 4

  assign ex_reg_write = ((id_op == cpu_pkg::op_rtype) || (id_op == cpu_pkg::op_addi) ||
                         (id_op == cpu_pkg::op_slti)  || (id_op == cpu_pkg::op_lw)) &&
                        (id_dest != '0);
  assign ex_load      = (id_op == cpu_pkg::op_lw);
  assign ex_dest      = id_dest;

  always_ff @(posedge clk) begin
    if (!nrst) begin
      ex_store <= 1'b0;
    end else begin
      ex_store <= (id_op == cpu_pkg::op_sw);
    end
  end

  always_ff @(posedge clk) begin
    ex_alu        <= alu_y;
    ex_store_data <= opnd_b;                    // Forwarded rd for sw
  end

endmodule

`default_nettype wire

/* rtl/result_stage.sv */
`default_nettype none

module result_stage (
  input  logic               clk,
  input  logic               nrst,
  input  cpu_pkg::word_t     ex_alu,
  input  cpu_pkg::word_t     ex_store_data,
  input  logic               ex_store,
  input  logic               ex_load,
  input  logic               ex_reg_write,
  input  cpu_pkg::reg_addr_t ex_dest,
  input  cpu_pkg::word_t     data_in,
  output cpu_pkg::word_t     data_addr,
  output cpu_pkg::word_t     data_out,
  output logic               data_wr,
  output logic               mem_reg_write,
  output cpu_pkg::reg_addr_t mem_dest,
  output cpu_pkg::word_t     mem_result,
  output logic               wb_reg_write,
  output cpu_pkg::reg_addr_t wb_dest,
  output cpu_pkg::word_t     wb_result,
  output cpu_pkg::word_t     retire_result
);

  logic mem_load;

  // Control half of EX/MEM, aligned with ex_alu
  always_ff @(posedge clk) begin
    if (!nrst) begin
      mem_load      <= 1'b0;
      mem_reg_write <= 1'b0;
      mem_dest      <= '0;
    end else begin
      mem_load      <= ex_load;
      mem_reg_write <= ex_reg_write;
      mem_dest      <= ex_dest;
    end
  end

  assign data_addr  = ex_alu;
  assign data_out   = ex_store_data;
  assign data_wr    = ex_store;
  assign mem_result = mem_load ? data_in : ex_alu;   // Load data forwards directly

  always_ff @(posedge clk) begin
    if (!nrst) begin
      wb_reg_write <= 1'b0;
      wb_dest      <= '0;
    end else begin
      wb_reg_write <= mem_reg_write;
      wb_dest      <= mem_dest;
    end
  end

  always_ff @(posedge clk) begin
    wb_result     <= mem_result;
    retire_result <= wb_result;           // Covers the cycle of the register write
  end

endmodule

`default_nettype wire

/* rtl/pipeline_cpu.sv */
`default_nettype none

module pipeline_cpu (
  input  logic           clk,
  input  logic           nrst,
  input  cpu_pkg::word_t inst,
  input  cpu_pkg::word_t data_in,
  output cpu_pkg::word_t inst_addr,
  output cpu_pkg::word_t data_addr,
  output cpu_pkg::word_t data_out,
  output logic           data_wr
);

  cpu_pkg::word_t     if_inst;
  cpu_pkg::word_t     if_pc_next;
  logic               stall;
  logic               branch_taken;
  cpu_pkg::word_t     branch_target;

  cpu_pkg::opcode_e   id_op;
  cpu_pkg::funct_e    id_funct;
  cpu_pkg::word_t     id_a;
  cpu_pkg::word_t     id_b;
  cpu_pkg::word_t     id_imm;
  cpu_pkg::word_t     id_pc_next;
  cpu_pkg::reg_addr_t id_dest;
  cpu_pkg::fwd_sel_e  id_fwd_a;
  cpu_pkg::fwd_sel_e  id_fwd_b;

  logic               ex_reg_write;     // Instruction now in execute
  logic               ex_load;
  cpu_pkg::reg_addr_t ex_dest;
  cpu_pkg::word_t     ex_alu;
  cpu_pkg::word_t     ex_store_data;
  logic               ex_store;

  logic               mem_reg_write;
  cpu_pkg::reg_addr_t mem_dest;
  cpu_pkg::word_t     mem_result;
  logic               wb_reg_write;
  cpu_pkg::reg_addr_t wb_dest;
  cpu_pkg::word_t     wb_result;
  cpu_pkg::word_t     retire_result;

  fetch_stage u_fetch (
    .clk           (clk),
    .nrst          (nrst),
    .inst          (inst),
    .stall         (stall),
    .branch_taken  (branch_taken),
    .branch_target (branch_target),
    .inst_addr     (inst_addr),
    .if_inst       (if_inst),
    .if_pc_next    (if_pc_next)
  );

  decode_stage u_decode (
    .clk           (clk),
    .nrst          (nrst),
    .if_inst       (if_inst),
    .if_pc_next    (if_pc_next),
    .branch_taken  (branch_taken),
    .ex_reg_write  (ex_reg_write),
    .ex_load       (ex_load),
    .ex_dest       (ex_dest),
    .mem_dest      (mem_dest),
    .mem_reg_write (mem_reg_write),
    .wb_reg_write  (wb_reg_write),
    .wb_dest       (wb_dest),
    .wb_result     (wb_result),
    .stall         (stall),
    .id_op         (id_op),
    .id_funct      (id_funct),
    .id_a          (id_a),
    .id_b          (id_b),
    .id_imm        (id_imm),
    .id_pc_next    (id_pc_next),
    .id_dest       (id_dest),
    .id_fwd_a      (id_fwd_a),
    .id_fwd_b      (id_fwd_b)
  );

  execute_stage u_execute (
    .clk           (clk),
    .nrst          (nrst),
    .id_op         (id_op),
    .id_funct      (id_funct),
    .id_a          (id_a),
    .id_b          (id_b),
    .id_imm        (id_imm),
    .id_pc_next    (id_pc_next),
    .id_dest       (id_dest),
    .id_fwd_a      (id_fwd_a),
    .id_fwd_b      (id_fwd_b),
    .mem_result    (mem_result),
    .wb_result     (wb_result),
    .retire_result (retire_result),
    .branch_taken  (branch_taken),
    .branch_target (branch_target),
    .ex_reg_write  (ex_reg_write),
    .ex_load       (ex_load),
    .ex_dest       (ex_dest),
    .ex_alu        (ex_alu),
    .ex_store_data (ex_store_data),
    .ex_store      (ex_store)
  );

  result_stage u_result (
    .clk           (clk),
    .nrst          (nrst),
    .ex_alu        (ex_alu),
    .ex_store_data (ex_store_data),
    .ex_store      (ex_store),
    .ex_load       (ex_load),
    .ex_reg_write  (ex_reg_write),
    .ex_dest       (ex_dest),
    .data_in       (data_in),
    .data_addr     (data_addr),
    .data_out      (data_out),
    .data_wr       (data_wr),
    .mem_reg_write (mem_reg_write),
    .mem_dest      (mem_dest),
    .mem_result    (mem_result),
    .wb_reg_write  (wb_reg_write),
    .wb_dest       (wb_dest),
    .wb_result     (wb_result),
    .retire_result (retire_result)
  );

endmodule

`default_nettype wire

/* test/isa_model.svh */
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

// Field layout: funct 31:25, rs2 24:20, rs1 19:15, imm 14:11, rd 10:6, opcode 5:0
function automatic cpu_pkg::word_t r_type_word(input logic [6:0] fn, input logic [4:0] rd,
                                               input logic [4:0] rs1, input logic [4:0] rs2);
  return {fn, rs2, rs1, 4'h0, rd, cpu_pkg::op_rtype};
endfunction

function automatic cpu_pkg::word_t imm_word(input cpu_pkg::opcode_e op, input logic [4:0] rd,
                                            input logic [4:0] rs1, input logic [15:0] imm);
  return {imm[15:4], rs1, imm[3:0], rd, op};      // High imm bits share rs2 and funct
endfunction

function automatic cpu_pkg::word_t branch_word(input cpu_pkg::opcode_e op,
                                               input logic [4:0] rs1, input logic [4:0] rs2,
                                               input logic [15:0] off);
  return {off[15:9], rs2, rs1, off[8:0], op};     // Low offset bits fill rd and imm
endfunction

// Sequential interpreter, one instruction at a time, fills the expected store list
task automatic interpret_program();
  cpu_pkg::word_t regs [32];
  cpu_pkg::word_t pc;
  cpu_pkg::word_t iw;
  cpu_pkg::word_t a;
  cpu_pkg::word_t b;
  cpu_pkg::word_t imm;
  cpu_pkg::word_t off;
  cpu_pkg::word_t res;
  cpu_pkg::word_t addr;
  logic [4:0]     rd;
  logic           wr;
  for (int i = 0; i < 32; i++) begin
    regs[i] = '0;
  end
  pc = '0;
  while (pc < cpu_pkg::word_t'(end_addr)) begin
    iw  = rom_word(pc);
    rd  = iw[10:6];
    a   = regs[iw[19:15]];
    b   = regs[iw[24:20]];
    imm = {{16{iw[31]}}, iw[31:20], iw[14:11]};
    off = {{16{iw[31]}}, iw[31:25], iw[14:6]};
    wr  = 1'b0;
    res = '0;
    pc  = pc + 32'd4;
    case (iw[5:0])
      cpu_pkg::op_rtype: begin
        wr = 1'b1;
        case (iw[31:25])
          cpu_pkg::fn_add: res = a + b;
          cpu_pkg::fn_sub: res = a - b;
          cpu_pkg::fn_slt: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          default:         res = '0;
        endcase
      end
      cpu_pkg::op_addi: begin
        wr  = 1'b1;
        res = a + imm;
      end
      cpu_pkg::op_slti: begin
        wr  = 1'b1;
        res = ($signed(a) < $signed(imm)) ? 32'd1 : 32'd0;
      end
      cpu_pkg::op_lw: begin
        wr   = 1'b1;
        addr = a + imm;
        res  = model_mem.exists(addr >> 2) ? model_mem[addr >> 2] : mem_pattern(addr >> 2);
      end
      cpu_pkg::op_sw: begin
        addr = a + imm;
        exp_addr.push_back(addr);
        exp_data.push_back(regs[rd]);               // Data comes from rd
        model_mem[addr >> 2] = regs[rd];
      end
      cpu_pkg::op_beq: begin
        if (a == b) begin
          pc = pc + off;
        end
      end
      cpu_pkg::op_bne: begin
        if (a != b) begin
          pc = pc + off;
        end
      end
      default: begin
      end
    endcase
    if (wr && rd != 5'd0) begin
      regs[rd] = res;
    end
  end
endtask

`endif

/* test/tb_pipeline_cpu.sv */
`default_nettype none

module tb_pipeline_cpu;

  localparam int prologue_len = 7;                  // Seeds r1 to r7
  localparam int random_len   = 200;
  localparam int pad_len      = 8;
  localparam int rom_words    = prologue_len + random_len + pad_len;
  localparam int end_addr     = rom_words * 4;
  localparam int cycle_limit  = 3 * rom_words + 40;
  localparam int drain_cycles = 4;                  // Fetch to memory is three stages
  localparam cpu_pkg::word_t nop_word = 32'h0000_003F;

  logic           clk = 1'b0;
  logic           nrst;
  cpu_pkg::word_t inst;
  cpu_pkg::word_t data_in;
  cpu_pkg::word_t inst_addr;
  cpu_pkg::word_t data_addr;
  cpu_pkg::word_t data_out;
  logic           data_wr;

  cpu_pkg::word_t rom [rom_words];
  cpu_pkg::word_t dmem [cpu_pkg::word_t];           // Written words, keyed by word address
  cpu_pkg::word_t model_mem [cpu_pkg::word_t];
  cpu_pkg::word_t exp_addr [$];
  cpu_pkg::word_t exp_data [$];
  cpu_pkg::word_t lfsr;
  int             stores_seen;
  int             value_errors;
  int             other_errors;
  int             cycles;

  pipeline_cpu dut (
    .clk       (clk),
    .nrst      (nrst),
    .inst      (inst),
    .data_in   (data_in),
    .inst_addr (inst_addr),
    .data_addr (data_addr),
    .data_out  (data_out),
    .data_wr   (data_wr)
  );

  always #50 clk = ~clk;

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic cpu_pkg::word_t take_bits(input int n);
    cpu_pkg::word_t v;
    logic           fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic cpu_pkg::word_t mem_pattern(input cpu_pkg::word_t waddr);
    return waddr ^ {waddr[15:0], waddr[31:16]} ^ 32'hC3A5_5A3C;
  endfunction

  function automatic cpu_pkg::word_t rom_word(input cpu_pkg::word_t addr);
    if (addr < cpu_pkg::word_t'(end_addr)) begin
      return rom[addr[9:2]];
    end
    return nop_word;                                // Past the end reads no-ops
  endfunction

  function automatic cpu_pkg::word_t read_data(input cpu_pkg::word_t addr);
    if (dmem.exists(addr >> 2)) begin
      return dmem[addr >> 2];
    end
    return mem_pattern(addr >> 2);
  endfunction

  `include "isa_model.svh"

  function automatic cpu_pkg::word_t random_inst();
    logic [3:0]     kind;
    logic [4:0]     rd;
    logic [4:0]     rs1;
    logic [4:0]     rs2;
    logic [15:0]    imm;
    logic [3:0]     span;
    cpu_pkg::word_t w;
    kind = 4'(take_bits(4));
    rd   = 5'(take_bits(3));                        // Few registers, dense dependences
    rs1  = 5'(take_bits(3));
    rs2  = 5'(take_bits(3));
    imm  = 16'(take_bits(16));
    span = {1'b0, imm[2:0]} + 4'd1;                 // Forward by 1 to 8 words
    case (kind)
      4'd0, 4'd1:        w = r_type_word(cpu_pkg::fn_add, rd, rs1, rs2);
      4'd2:              w = r_type_word(cpu_pkg::fn_sub, rd, rs1, rs2);
      4'd3:              w = r_type_word(cpu_pkg::fn_slt, rd, rs1, rs2);
      4'd4:              w = r_type_word(7'h00, rd, rs1, rs2);   // Unsupported funct
      4'd5, 4'd6:        w = imm_word(cpu_pkg::op_addi, rd, rs1, imm);
      4'd7:              w = imm_word(cpu_pkg::op_slti, rd, rs1, imm);
      4'd8, 4'd9:        w = imm_word(cpu_pkg::op_lw, rd, imm[3] ? 5'd0 : rs1,
                                      {11'b0, imm[6:4], 2'b00});
      4'd10, 4'd11,
      4'd12:             w = imm_word(cpu_pkg::op_sw, rd, imm[3] ? 5'd0 : rs1,
                                      {11'b0, imm[6:4], 2'b00});
      4'd13:             w = branch_word(cpu_pkg::op_beq, rs1, rs2, {10'b0, span, 2'b00});
      4'd14:             w = branch_word(cpu_pkg::op_bne, rs1, rs2, {10'b0, span, 2'b00});
      default:           w = nop_word;
    endcase
    return w;
  endfunction

  task automatic build_program();
    for (int i = 0; i < rom_words; i++) begin
      if (i < prologue_len) begin
        rom[i] = imm_word(cpu_pkg::op_addi, 5'(i + 1), 5'd0, 16'(take_bits(16)));
      end else if (i < prologue_len + random_len) begin
        rom[i] = random_inst();
      end else begin
        rom[i] = nop_word;
      end
    end
  endtask

  task automatic check_word(input string name, input cpu_pkg::word_t got,
                            input cpu_pkg::word_t exp);
    if (got !== exp) begin
      $display("ERROR t=%0t %s got %h expected %h", $time, name, got, exp);
      value_errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERROR t=%0t %s got %b expected %b", $time, name, got, exp);
      value_errors++;
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("ERROR t=%0t %s got %0d expected %0d", $time, name, got, exp);
      value_errors++;
    end
  endtask

  // Falling edge: retire a store, then answer both memories for the next rising edge
  task automatic step_cycle();
    @(negedge clk);
    if (data_wr) begin
      if (stores_seen < exp_addr.size()) begin
        check_word("data_addr", data_addr, exp_addr[stores_seen]);
        check_word("data_out", data_out, exp_data[stores_seen]);
      end else begin
        $display("ERROR t=%0t unexpected store to %h after all %0d expected stores",
                 $time, data_addr, exp_addr.size());
        other_errors++;
      end
      stores_seen++;
      dmem[data_addr >> 2] = data_out;
    end
    inst    = rom_word(inst_addr);
    data_in = read_data(data_addr);
  endtask

  initial begin
    nrst         = 1'b0;
    inst         = nop_word;
    data_in      = '0;
    lfsr         = 32'h05442dd2;
    stores_seen  = 0;
    value_errors = 0;
    other_errors = 0;
    cycles       = 0;
    build_program();
    interpret_program();

    repeat (2) begin
      step_cycle();
      check_bit("data_wr", data_wr, 1'b0);
      check_word("inst_addr", inst_addr, '0);
    end
    nrst = 1'b1;

    while (inst_addr < cpu_pkg::word_t'(end_addr) && cycles < cycle_limit) begin
      step_cycle();
      cycles++;
    end
    if (cycles >= cycle_limit) begin
      $display("Timeout: fetch did not reach the end of the program in %0d cycles",
               cycle_limit);
      other_errors++;
    end else begin
      repeat (drain_cycles) step_cycle();       // Let in-flight stores reach memory
    end

    check_count("store count", stores_seen, exp_addr.size());
    $display("stores %0d of %0d, value errors %0d, other errors %0d",
             stores_seen, exp_addr.size(), value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
+incdir+test
rtl/cpu_pkg.sv
rtl/reg_file.sv
rtl/hazard_unit.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/result_stage.sv
rtl/pipeline_cpu.sv
test/tb_pipeline_cpu.sv

/* run.sh */
#!/bin/sh
# Build and run the pipeline CPU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_pipeline_cpu -Mdir build -f flist.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./build/Vtb_pipeline_cpu > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qF '** FAIL **' sim.log; then
  exit 1
fi
exit 0
